// File: bridge_consts.svh
`ifndef BRIDGE_CONSTS_SVH
`define BRIDGE_CONSTS_SVH

// ====================================================================
// endpoint numbers seen on the controller's endpoint select
// ====================================================================
`define EP_UART_CONFIG  4'd0  // reserved, no function behind it
`define EP_UART1_DATA   4'd5  // uart data endpoint
`define EP_PARALLEL     4'd8  // gpio endpoint

// ====================================================================
// default sizes and periods
// ====================================================================
`define UART_CLK_DIV_DEFAULT      520       // clocks per uart bit
`define HEARTBEAT_CYCLES_DEFAULT  60000000  // clocks between led toggles
`define BYTE_FIFO_DEPTH           16        // entries per uart fifo

`endif

// File: bridge_pkg.sv
package bridge_pkg;

  typedef logic [3:0]  endpt_t;     // endpoint number
  typedef logic [7:0]  byte_t;      // stream / uart byte
  typedef logic [11:0] pkt_len_t;   // in packet length
  typedef logic [9:0]  gpio_t;      // parallel output word
  typedef logic [4:0]  fifo_cnt_t;  // 0..16 entries

  // uart line engine, shared by tx and rx sides
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_START,
    ST_DATA,
    ST_STOP
  } uart_state_t;

endpackage

// File: ep_stream_if.sv
`timescale 1ns/1ns

interface ep_stream_if;
  import bridge_pkg::*;

  // out direction, controller to function
  byte_t    rxdat;
  logic     rxval;     // one strobe per byte
  logic     rxact;     // high for the whole packet
  logic     rxpktval;  // good packet pulse
  logic     rxrdy;

  // in direction, function to controller
  logic     txact;
  logic     txpop;     // one pulse per byte taken
  byte_t    txdat;
  pkt_len_t txlen;
  logic     txcork;    // low when data is waiting

  modport router (
    output rxdat, rxval, rxact, rxpktval, txact, txpop,
    input  rxrdy, txdat, txlen, txcork
  );

  modport func (
    input  rxdat, rxval, rxact, rxpktval, txact, txpop,
    output rxrdy, txdat, txlen, txcork
  );

endinterface

// File: byte_fifo.sv
`timescale 1ns/1ns
`include "bridge_consts.svh"

module byte_fifo #(
  parameter int DEPTH = `BYTE_FIFO_DEPTH
) (
  input  logic                  PHY_CLKOUT,
  input  logic                  RESET_IN,
  input  logic                  push_i,
  input  bridge_pkg::byte_t     push_data_i,
  input  logic                  pop_i,
  output bridge_pkg::byte_t     head_o,
  output bridge_pkg::fifo_cnt_t count_o
);
  import bridge_pkg::*;

  localparam int PTR_W = $clog2(DEPTH);

  byte_t            mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic             push_ok;
  logic             pop_ok;

  assign push_ok = push_i && (count_o != fifo_cnt_t'(DEPTH));  // drop when full
  assign pop_ok  = pop_i && (count_o != '0);
  assign head_o  = mem[rd_ptr];  // show-ahead

  always_ff @(posedge PHY_CLKOUT) begin
    if (push_ok) begin
      mem[wr_ptr] <= push_data_i;
    end
  end

  always_ff @(posedge PHY_CLKOUT) begin
    if (RESET_IN) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count_o <= '0;
    end else begin
      if (push_ok) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop_ok) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count_o <= count_o + fifo_cnt_t'(push_ok) - fifo_cnt_t'(pop_ok);
    end
  end

endmodule

// File: uart_line.sv
`timescale 1ns/1ns
`include "bridge_consts.svh"

module uart_line #(
  parameter int CLK_DIV = `UART_CLK_DIV_DEFAULT
) (
  input  logic              PHY_CLKOUT,
  input  logic              RESET_IN,
  input  logic              tx_start_i,
  input  bridge_pkg::byte_t tx_data_i,
  output logic              tx_busy_o,
  output bridge_pkg::byte_t rx_data_o,
  output logic              rx_valid_o,
  input  logic              uart_rxd_i,
  output logic              uart_txd_o
);
  import bridge_pkg::*;

  localparam int CNT_W = $clog2(CLK_DIV);

  uart_state_t      tx_state;
  logic [CNT_W-1:0] tx_cnt;
  logic [2:0]       tx_bit;
  byte_t            tx_shift;
  logic             tx_bit_end;
  uart_state_t      rx_state;
  logic [CNT_W-1:0] rx_cnt;
  logic [2:0]       rx_bit;
  logic [1:0]       rxd_sync;
  logic             rxd_prev;

  //======================================================================
  // transmitter, 8N1
  //======================================================================
  assign tx_bit_end = (tx_cnt == CNT_W'(CLK_DIV - 1));
  assign tx_busy_o  = (tx_state != ST_IDLE);

  always_ff @(posedge PHY_CLKOUT) begin
    if (RESET_IN) begin
      tx_state   <= ST_IDLE;
      tx_cnt     <= '0;
      tx_bit     <= '0;
      uart_txd_o <= 1'b1;  // line idles high
    end else begin
      tx_cnt <= tx_bit_end ? '0 : tx_cnt + 1'b1;
      case (tx_state)
        ST_IDLE: begin
          tx_cnt <= '0;
          if (tx_start_i) begin
            tx_shift   <= tx_data_i;
            uart_txd_o <= 1'b0;  // start bit
            tx_state   <= ST_START;
          end
        end
        ST_START: if (tx_bit_end) begin
          tx_bit     <= '0;
          uart_txd_o <= tx_shift[0];
          tx_state   <= ST_DATA;
        end
        ST_DATA: if (tx_bit_end) begin
          if (tx_bit == 3'd7) begin
            uart_txd_o <= 1'b1;  // stop bit
            tx_state   <= ST_STOP;
          end else begin
            tx_bit     <= tx_bit + 3'd1;
            tx_shift   <= tx_shift >> 1;
            uart_txd_o <= tx_shift[1];  // lsb first
          end
        end
        ST_STOP: if (tx_bit_end) tx_state <= ST_IDLE;
        default: tx_state <= ST_IDLE;
      endcase
    end
  end

  //======================================================================
  // receiver, mid-bit sampling
  //======================================================================
  always_ff @(posedge PHY_CLKOUT) begin
    if (RESET_IN) begin
      rxd_sync   <= 2'b11;
      rxd_prev   <= 1'b1;
      rx_state   <= ST_IDLE;
      rx_cnt     <= '0;
      rx_bit     <= '0;
      rx_valid_o <= 1'b0;
    end else begin
      rxd_sync   <= {rxd_sync[0], uart_rxd_i};  // two flop synchronizer
      rxd_prev   <= rxd_sync[1];
      rx_valid_o <= 1'b0;
      rx_cnt     <= rx_cnt + 1'b1;
      case (rx_state)
        ST_IDLE: begin
          rx_cnt <= '0;
          if (rxd_prev && !rxd_sync[1]) rx_state <= ST_START;  // falling edge only
        end
        ST_START: if (rx_cnt == CNT_W'(CLK_DIV / 2 - 1)) begin
          rx_cnt   <= '0;
          rx_bit   <= '0;
          rx_state <= rxd_sync[1] ? ST_IDLE : ST_DATA;  // glitch returns to idle
        end
        ST_DATA: if (rx_cnt == CNT_W'(CLK_DIV - 1)) begin
          rx_cnt    <= '0;
          rx_data_o <= {rxd_sync[1], rx_data_o[7:1]};
          rx_bit    <= rx_bit + 3'd1;
          if (rx_bit == 3'd7) rx_state <= ST_STOP;
        end
        ST_STOP: if (rx_cnt == CNT_W'(CLK_DIV - 1)) begin
          rx_valid_o <= rxd_sync[1];  // low stop bit drops the frame
          rx_state   <= ST_IDLE;
        end
        default: rx_state <= ST_IDLE;
      endcase
    end
  end

endmodule

// File: heartbeat_led.sv
`timescale 1ns/1ns
`include "bridge_consts.svh"

module heartbeat_led #(
  parameter int HEARTBEAT_CYCLES = `HEARTBEAT_CYCLES_DEFAULT
) (
  input  logic PHY_CLKOUT,
  input  logic RESET_IN,
  output logic led_o
);

  localparam int CNT_W = $clog2(HEARTBEAT_CYCLES);

  logic [CNT_W-1:0] cnt;

  always_ff @(posedge PHY_CLKOUT) begin
    if (RESET_IN) begin
      cnt   <= '0;
      led_o <= 1'b0;
    end else if (cnt == CNT_W'(HEARTBEAT_CYCLES - 1)) begin
      cnt   <= '0;
      led_o <= ~led_o;  // one toggle per wrap
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

endmodule

// File: gpio_endpoint.sv
`timescale 1ns/1ns

module gpio_endpoint (
  input  logic              PHY_CLKOUT,
  input  logic              RESET_IN,
  ep_stream_if.func         ep,
  output bridge_pkg::gpio_t parallel_gpio_o
);
  import bridge_pkg::*;

  logic       rxact_q;
  logic       pkt_start;
  logic [1:0] byte_idx;   // saturates at 2, later bytes ignored
  logic [1:0] idx_cur;
  logic [1:0] idx_nxt;
  gpio_t      stage;
  gpio_t      stage_nxt;

  assign pkt_start = ep.rxact & ~rxact_q;

  // out only, never offers in data
  assign ep.rxrdy  = 1'b1;
  assign ep.txcork = 1'b1;
  assign ep.txdat  = '0;
  assign ep.txlen  = '0;

  always_comb begin
    idx_cur   = pkt_start ? 2'd0 : byte_idx;  // first byte may share the start cycle
    stage_nxt = pkt_start ? '0 : stage;
    idx_nxt   = idx_cur;
    if (ep.rxval) begin
      case (idx_cur)
        2'd0:    stage_nxt[7:0] = ep.rxdat;
        2'd1:    stage_nxt[9:8] = ep.rxdat[1:0];
        default: ;
      endcase
      if (idx_cur != 2'd2) begin
        idx_nxt = idx_cur + 2'd1;
      end
    end
  end

  always_ff @(posedge PHY_CLKOUT) begin
    if (RESET_IN) begin
      rxact_q         <= 1'b0;
      byte_idx        <= '0;
      stage           <= '0;
      parallel_gpio_o <= '0;
    end else begin
      rxact_q  <= ep.rxact;
      byte_idx <= idx_nxt;
      stage    <= stage_nxt;
      if (ep.rxpktval) begin
        parallel_gpio_o <= stage;  // only good packets reach the pins
      end
    end
  end

endmodule

// File: uart_endpoint.sv
`timescale 1ns/1ns
`include "bridge_consts.svh"

module uart_endpoint #(
  parameter int CLK_DIV = `UART_CLK_DIV_DEFAULT
) (
  input  logic      PHY_CLKOUT,
  input  logic      RESET_IN,
  ep_stream_if.func ep,
  input  logic      uart_rxd_i,
  output logic      uart_txd_o
);
  import bridge_pkg::*;

  byte_t     tx_head;
  fifo_cnt_t tx_count;
  logic      tx_start;
  logic      tx_busy;
  byte_t     rx_data;
  logic      rx_valid;
  fifo_cnt_t rx_count;
  pkt_len_t  len_hold;  // length as it was before txact rose

  //======================================================================
  // out path, usb to line
  //======================================================================
  byte_fifo #(.DEPTH(`BYTE_FIFO_DEPTH)) tx_fifo (
    .PHY_CLKOUT  (PHY_CLKOUT),
    .RESET_IN    (RESET_IN),
    .push_i      (ep.rxval),
    .push_data_i (ep.rxdat),
    .pop_i       (tx_start),
    .head_o      (tx_head),
    .count_o     (tx_count)
  );

  assign tx_start = ~tx_busy && (tx_count != '0);
  assign ep.rxrdy = (tx_count == '0);  // next packet waits for a drained fifo

  uart_line #(.CLK_DIV(CLK_DIV)) u_line (
    .PHY_CLKOUT (PHY_CLKOUT),
    .RESET_IN   (RESET_IN),
    .tx_start_i (tx_start),
    .tx_data_i  (tx_head),
    .tx_busy_o  (tx_busy),
    .rx_data_o  (rx_data),
    .rx_valid_o (rx_valid),
    .uart_rxd_i (uart_rxd_i),
    .uart_txd_o (uart_txd_o)
  );

  //======================================================================
  // in path, line to usb
  //======================================================================
  byte_fifo #(.DEPTH(`BYTE_FIFO_DEPTH)) rx_fifo (
    .PHY_CLKOUT  (PHY_CLKOUT),
    .RESET_IN    (RESET_IN),
    .push_i      (rx_valid),
    .push_data_i (rx_data),
    .pop_i       (ep.txpop),
    .head_o      (ep.txdat),
    .count_o     (rx_count)
  );

  always_ff @(posedge PHY_CLKOUT) begin
    if (RESET_IN) begin
      len_hold <= '0;
    end else if (!ep.txact) begin
      len_hold <= pkt_len_t'(rx_count);  // frozen during a transfer
    end
  end

  assign ep.txcork = (rx_count == '0);
  assign ep.txlen  = ep.txact ? len_hold : pkt_len_t'(rx_count);

endmodule

// File: endpoint_router.sv
`timescale 1ns/1ns
`include "bridge_consts.svh"

module endpoint_router (
  input  bridge_pkg::endpt_t   usb_endpt_i,
  input  bridge_pkg::byte_t    usb_rxdat_i,
  input  logic                 usb_rxval_i,
  input  logic                 usb_rxact_i,
  input  logic                 usb_rxpktval_i,
  output logic                 usb_rxrdy_o,
  input  logic                 usb_txact_i,
  input  logic                 usb_txpop_i,
  output bridge_pkg::byte_t    usb_txdat_o,
  output bridge_pkg::pkt_len_t usb_txdat_len_o,
  output logic                 usb_txcork_o,
  ep_stream_if.router          gpio_ep,
  ep_stream_if.router          uart_ep
);

  logic sel_gpio;
  logic sel_uart;

  assign sel_gpio = (usb_endpt_i == `EP_PARALLEL);
  assign sel_uart = (usb_endpt_i == `EP_UART1_DATA);

  // data and activity levels go to everyone
  assign gpio_ep.rxdat    = usb_rxdat_i;
  assign gpio_ep.rxact    = usb_rxact_i;
  assign gpio_ep.txact    = usb_txact_i;
  assign uart_ep.rxdat    = usb_rxdat_i;
  assign uart_ep.rxact    = usb_rxact_i;
  assign uart_ep.txact    = usb_txact_i;

  // strobes only reach the selected endpoint
  assign gpio_ep.rxval    = usb_rxval_i & sel_gpio;
  assign gpio_ep.rxpktval = usb_rxpktval_i & sel_gpio;
  assign gpio_ep.txpop    = usb_txpop_i & sel_gpio;
  assign uart_ep.rxval    = usb_rxval_i & sel_uart;
  assign uart_ep.rxpktval = usb_rxpktval_i & sel_uart;
  assign uart_ep.txpop    = usb_txpop_i & sel_uart;

  always_comb begin
    usb_rxrdy_o     = 1'b0;  // idle answer for unknown endpoints
    usb_txcork_o    = 1'b1;
    usb_txdat_o     = '0;
    usb_txdat_len_o = '0;
    case (usb_endpt_i)
      `EP_PARALLEL: begin
        usb_rxrdy_o     = gpio_ep.rxrdy;
        usb_txcork_o    = gpio_ep.txcork;
        usb_txdat_o     = gpio_ep.txdat;
        usb_txdat_len_o = gpio_ep.txlen;
      end
      `EP_UART1_DATA: begin
        usb_rxrdy_o     = uart_ep.rxrdy;
        usb_txcork_o    = uart_ep.txcork;
        usb_txdat_o     = uart_ep.txdat;
        usb_txdat_len_o = uart_ep.txlen;
      end
      `EP_UART_CONFIG: ;  // no config function, answer as unknown
      default: ;
    endcase
  end

endmodule

// File: usb_bridge_top.sv
`timescale 1ns/1ns
`include "bridge_consts.svh"

module usb_bridge_top #(
  parameter int CLK_DIV          = `UART_CLK_DIV_DEFAULT,
  parameter int HEARTBEAT_CYCLES = `HEARTBEAT_CYCLES_DEFAULT
) (
  input  logic                PHY_CLKOUT,
  input  logic                RESET_IN,
  input  bridge_pkg::endpt_t  usb_endpt_i,
  input  bridge_pkg::byte_t   usb_rxdat_i,
  input  logic                usb_rxval_i,
  input  logic                usb_rxact_i,
  input  logic                usb_rxpktval_i,
  output logic                usb_rxrdy_o,
  input  logic                usb_txact_i,
  input  logic                usb_txpop_i,
  output bridge_pkg::byte_t   usb_txdat_o,
  output bridge_pkg::pkt_len_t usb_txdat_len_o,
  output logic                usb_txcork_o,
  input  logic                uart_rxd_i,
  output logic                uart_txd_o,
  output bridge_pkg::gpio_t   parallel_gpio_o,
  output logic                led_o
);

  ep_stream_if gpio_ep ();
  ep_stream_if uart_ep ();

  //======================================================================
  // endpoint steering
  //======================================================================
  endpoint_router u_router (
    .usb_endpt_i     (usb_endpt_i),
    .usb_rxdat_i     (usb_rxdat_i),
    .usb_rxval_i     (usb_rxval_i),
    .usb_rxact_i     (usb_rxact_i),
    .usb_rxpktval_i  (usb_rxpktval_i),
    .usb_rxrdy_o     (usb_rxrdy_o),
    .usb_txact_i     (usb_txact_i),
    .usb_txpop_i     (usb_txpop_i),
    .usb_txdat_o     (usb_txdat_o),
    .usb_txdat_len_o (usb_txdat_len_o),
    .usb_txcork_o    (usb_txcork_o),
    .gpio_ep         (gpio_ep.router),
    .uart_ep         (uart_ep.router)
  );

  //======================================================================
  // function endpoints
  //======================================================================
  gpio_endpoint u_gpio_ep (
    .PHY_CLKOUT      (PHY_CLKOUT),
    .RESET_IN        (RESET_IN),
    .ep              (gpio_ep.func),
    .parallel_gpio_o (parallel_gpio_o)
  );

  uart_endpoint #(.CLK_DIV(CLK_DIV)) u_uart_ep (
    .PHY_CLKOUT (PHY_CLKOUT),
    .RESET_IN   (RESET_IN),
    .ep         (uart_ep.func),
    .uart_rxd_i (uart_rxd_i),
    .uart_txd_o (uart_txd_o)
  );

  heartbeat_led #(.HEARTBEAT_CYCLES(HEARTBEAT_CYCLES)) u_heartbeat (
    .PHY_CLKOUT (PHY_CLKOUT),
    .RESET_IN   (RESET_IN),
    .led_o      (led_o)
  );

endmodule

// File: tb_usb_bridge.sv
`timescale 1ns/1ns
`include "bridge_consts.svh"

module tb_usb_bridge;
  import bridge_pkg::*;

  localparam int CLK_DIV        = 8;
  localparam int HB_CYCLES      = 200;
  localparam int NUM_OUT_PKTS   = 6;
  localparam int MAX_PKT_BYTES  = 16;
  localparam int FRAME_BITS     = 10;
  localparam int TIMEOUT_CYCLES =
    (NUM_OUT_PKTS + 5) * MAX_PKT_BYTES * FRAME_BITS * CLK_DIV + 2000;

  logic     PHY_CLKOUT;
  logic     RESET_IN;
  endpt_t   usb_endpt_i;
  byte_t    usb_rxdat_i;
  logic     usb_rxval_i;
  logic     usb_rxact_i;
  logic     usb_rxpktval_i;
  logic     usb_rxrdy_o;
  logic     usb_txact_i;
  logic     usb_txpop_i;
  byte_t    usb_txdat_o;
  pkt_len_t usb_txdat_len_o;
  logic     usb_txcork_o;
  logic     uart_rxd_i;
  logic     uart_txd_o;
  gpio_t    parallel_gpio_o;
  logic     led_o;

  byte_t pkt_buf [MAX_PKT_BYTES];  // current out packet
  byte_t exp_tx [$];               // bytes still due on uart_txd_o
  byte_t rx_sent [$];              // bytes put on uart_rxd_i
  int    frames_started = 0;
  int    tx_bytes_sent  = 0;
  int    fail_count     = 0;
  int    cycle_count    = 0;
  int    hb_edges       = 0;

  usb_bridge_top #(.CLK_DIV(CLK_DIV), .HEARTBEAT_CYCLES(HB_CYCLES)) uut (.*);

  always #10 PHY_CLKOUT = ~PHY_CLKOUT;

  //======================================================================
  // reference models
  //======================================================================
  function automatic gpio_t expected_gpio(input byte_t b0, input byte_t b1, input int n);
    gpio_t w;
    w = '0;
    if (n >= 1) w[7:0] = b0;
    if (n >= 2) w[9:8] = b1[1:0];  // later bytes ignored
    return w;
  endfunction

  function automatic logic [9:0] frame_bits(input byte_t b);
    return {1'b1, b, 1'b0};  // stop, data lsb first, start in bit 0
  endfunction

  function automatic logic expected_led(input int cycles);
    return logic'((cycles / HB_CYCLES) % 2);
  endfunction

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected) begin
      fail_count = fail_count + 1;
      $display("MISMATCH at %0t ns: %s (got %0h, expected %0h)", $time, what, actual, expected);
      $display("CHECKS FAILED");
      $fatal(1);
    end
  endtask

  //======================================================================
  // controller and line models
  //======================================================================
  task automatic fill_random_packet(input int n);
    for (int i = 0; i < n; i++) pkt_buf[i] = byte_t'($urandom);
  endtask

  task automatic send_out_packet(input endpt_t ep, input int n, input bit good);
    usb_endpt_i = ep;
    @(negedge PHY_CLKOUT);
    while (!usb_rxrdy_o) @(negedge PHY_CLKOUT);  // wait for the endpoint
    usb_rxact_i = 1'b1;
    @(negedge PHY_CLKOUT);
    for (int i = 0; i < n; i++) begin
      if (ep == `EP_UART1_DATA) begin
        exp_tx.push_back(pkt_buf[i]);
        tx_bytes_sent = tx_bytes_sent + 1;
      end
      usb_rxdat_i = pkt_buf[i];
      usb_rxval_i = 1'b1;
      @(negedge PHY_CLKOUT);
    end
    usb_rxval_i    = 1'b0;
    usb_rxpktval_i = good;
    @(negedge PHY_CLKOUT);
    usb_rxpktval_i = 1'b0;
    usb_rxact_i    = 1'b0;
  endtask

  task automatic read_in_packet(input int n_expected);
    int len;
    usb_endpt_i = `EP_UART1_DATA;
    @(negedge PHY_CLKOUT);
    while (usb_txcork_o) @(negedge PHY_CLKOUT);
    len = int'(usb_txdat_len_o);
    check_value(len, n_expected, "in packet length");
    usb_txact_i = 1'b1;
    @(negedge PHY_CLKOUT);
    for (int i = 0; i < len; i++) begin
      check_value(usb_txdat_len_o, n_expected, "length held during transfer");
      check_value(usb_txdat_o, rx_sent[i], "in packet byte");
      usb_txpop_i = 1'b1;
      @(negedge PHY_CLKOUT);
    end
    usb_txpop_i = 1'b0;
    usb_txact_i = 1'b0;
    @(negedge PHY_CLKOUT);
    check_value(usb_txcork_o, 1'b1, "txcork after in packet");
  endtask

  task automatic send_line_frame(input byte_t b, input logic stop_bit);
    uart_rxd_i = 1'b0;  // start bit
    repeat (CLK_DIV) @(negedge PHY_CLKOUT);
    for (int i = 0; i < 8; i++) begin
      uart_rxd_i = b[i];
      repeat (CLK_DIV) @(negedge PHY_CLKOUT);
    end
    uart_rxd_i = stop_bit;
    repeat (CLK_DIV) @(negedge PHY_CLKOUT);
    uart_rxd_i = 1'b1;
  endtask

  task automatic send_line_burst(input int n);
    byte_t b;
    rx_sent.delete();
    for (int i = 0; i < n; i++) begin
      b = byte_t'($urandom);
      rx_sent.push_back(b);
      send_line_frame(b, 1'b1);
    end
    repeat (2 * CLK_DIV) @(negedge PHY_CLKOUT);  // let the last frame land
  endtask

  //======================================================================
  // monitors
  //======================================================================
  always begin : tx_line_compare
    logic [9:0] frame;
    @(negedge uart_txd_o);
    if (!RESET_IN) begin
      frames_started = frames_started + 1;
      repeat (CLK_DIV / 2) @(negedge PHY_CLKOUT);  // to mid start bit
      for (int k = 0; k < FRAME_BITS; k++) begin
        frame[k] = uart_txd_o;
        if (k != FRAME_BITS - 1) repeat (CLK_DIV) @(negedge PHY_CLKOUT);
      end
      check_value(exp_tx.size() != 0, 1'b1, "tx frame with no byte queued");
      check_value(frame, frame_bits(exp_tx.pop_front()), "tx frame");
    end
  end

  always @(posedge PHY_CLKOUT) begin
    hb_edges <= RESET_IN ? 0 : hb_edges + 1;  // edges since reset release
    cycle_count = cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("CHECKS FAILED");
      $fatal(1);
    end
  end

  always @(negedge PHY_CLKOUT) begin
    if (hb_edges != 0 && hb_edges % HB_CYCLES == HB_CYCLES / 2) begin
      check_value(led_o, expected_led(hb_edges), "heartbeat led");
    end
  end

  //======================================================================
  // test sequence
  //======================================================================
  initial begin
    int    seed_dummy;
    int    n;
    gpio_t gpio_word;
    PHY_CLKOUT     = 1'b0;
    RESET_IN       = 1'b1;
    usb_endpt_i    = `EP_UART1_DATA;
    usb_rxdat_i    = '0;
    usb_rxval_i    = 1'b0;
    usb_rxact_i    = 1'b0;
    usb_rxpktval_i = 1'b0;
    usb_txact_i    = 1'b0;
    usb_txpop_i    = 1'b0;
    uart_rxd_i     = 1'b1;
    seed_dummy     = $urandom(32'hc5f7_a275);
    repeat (3) @(negedge PHY_CLKOUT);
    RESET_IN = 1'b0;
    @(negedge PHY_CLKOUT);

    check_value(led_o, 1'b0, "led after reset");
    check_value(parallel_gpio_o, '0, "gpio after reset");
    check_value(uart_txd_o, 1'b1, "txd after reset");
    check_value(usb_rxrdy_o, 1'b1, "uart rxrdy after reset");
    check_value(usb_txcork_o, 1'b1, "uart txcork after reset");
    usb_endpt_i = 4'd3;  // no function behind it
    @(negedge PHY_CLKOUT);
    check_value(usb_rxrdy_o, 1'b0, "unknown endpoint rxrdy");
    check_value(usb_txcork_o, 1'b1, "unknown endpoint txcork");
    check_value(usb_txdat_o, '0, "unknown endpoint data");
    check_value(usb_txdat_len_o, '0, "unknown endpoint length");

    // gpio packets of two, one and several bytes, then a bad one
    for (int p = 0; p < 3; p++) begin
      n = (p < 2) ? 2 - p : 3 + $urandom % (MAX_PKT_BYTES - 2);
      fill_random_packet(n);
      if (p == 0) pkt_buf[1][0] = 1'b1;  // pin 8 high so the next packet must clear it
      send_out_packet(`EP_PARALLEL, n, 1'b1);
      gpio_word = expected_gpio(pkt_buf[0], pkt_buf[1], n);
      check_value(parallel_gpio_o, gpio_word, "gpio word");
    end
    fill_random_packet(4);
    send_out_packet(`EP_PARALLEL, 4, 1'b0);
    repeat (2) @(negedge PHY_CLKOUT);
    check_value(parallel_gpio_o, gpio_word, "gpio after packet without rxpktval");

    for (int p = 0; p < NUM_OUT_PKTS; p++) begin
      n = 1 + $urandom % MAX_PKT_BYTES;
      fill_random_packet(n);
      send_out_packet(`EP_UART1_DATA, n, 1'b1);
    end

    // back-pressure holds until the last queued frame starts
    n = 4 + $urandom % (MAX_PKT_BYTES - 3);
    fill_random_packet(n);
    send_out_packet(`EP_UART1_DATA, n, 1'b1);
    check_value(usb_rxrdy_o, 1'b0, "rxrdy right after uart packet");
    while (!usb_rxrdy_o) @(negedge PHY_CLKOUT);
    check_value(frames_started, tx_bytes_sent, "frames started when rxrdy returns");

    for (int p = 0; p < 2; p++) begin
      n = 1 + $urandom % MAX_PKT_BYTES;
      send_line_burst(n);
      read_in_packet(n);
    end

    // bad stop bit adds nothing, the next good frame still lands
    send_line_frame(byte_t'($urandom), 1'b0);
    repeat (2 * CLK_DIV) @(negedge PHY_CLKOUT);
    check_value(usb_txcork_o, 1'b1, "txcork after bad stop bit");
    send_line_burst(1);
    read_in_packet(1);

    while (exp_tx.size() != 0) @(negedge PHY_CLKOUT);
    repeat (2 * CLK_DIV) @(negedge PHY_CLKOUT);
    check_value(frames_started, tx_bytes_sent, "total tx frames");
    if (fail_count == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// File: list.f
+incdir+.
bridge_pkg.sv
ep_stream_if.sv
byte_fifo.sv
uart_line.sv
heartbeat_led.sv
gpio_endpoint.sv
uart_endpoint.sv
endpoint_router.sv
usb_bridge_top.sv
tb_usb_bridge.sv
